// File: verilog/mont_arith_pkg.sv
package mont_arith_pkg;

    // --------------------
    // word geometry
    // --------------------

    // bits per datapath word
    localparam int WORD_W   = 16;

    // words per operand
    localparam int N_WORDS  = 4;

    // full operand width
    localparam int OP_W     = WORD_W * N_WORDS;

    // word index width
    localparam int IDX_W    = $clog2(N_WORDS);

    // exponent walked bit by bit, msb first
    localparam int EXP_BITS = OP_W;

    // --------------------
    // operand types
    // --------------------

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [OP_W-1:0]   operand_t;

endpackage

// File: verilog/mont_const_pkg.sv
package mont_const_pkg;

    import mont_arith_pkg::*;

    // --------------------
    // fixed modulus
    // --------------------

    // m = 2^64 - 59, odd and prime
    localparam operand_t MODULUS  = 64'hffff_ffff_ffff_ffc5;

    // -m^-1 mod 2^16, which is 59^-1 because m is -59 in the low word
    localparam word_t    M_PRIME  = 16'hd8f3;

    // montgomery one, 2^64 mod m
    localparam operand_t R_MOD_M  = 64'h0000_0000_0000_003b;

    // 2^128 mod m, i.e. 59 squared
    localparam operand_t R2_MOD_M = 64'h0000_0000_0000_0d99;

    // --------------------
    // operand routing
    // --------------------

    typedef enum logic [0:0] {SRC_A_ACC, SRC_A_X} src_a_t;
    typedef enum logic [1:0] {SRC_B_R2, SRC_B_XM, SRC_B_ACC, SRC_B_ONE} src_b_t;
    typedef enum logic [1:0] {DST_XM, DST_ACC, DST_OUT} dst_t;

endpackage

// File: verilog/exp_sequencer.sv
`timescale 1ns/1ns

module exp_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    x_valid,
    input  logic                    y_valid,
    input  mont_arith_pkg::word_t   y_word,
    input  logic                    mul_done,
    output logic                    busy,
    output logic                    mul_start,
    output logic                    x_we,
    output logic                    acc_init,
    output mont_arith_pkg::idx_t    x_idx,
    output mont_const_pkg::src_a_t  src_a,
    output mont_const_pkg::src_b_t  src_b,
    output mont_const_pkg::dst_t    dst
);

    import mont_arith_pkg::*;
    import mont_const_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_X,
        S_CONV_IN,
        S_SQUARE,
        S_MULT,
        S_CONV_OUT
    } state_t;

    state_t                           state;
    logic [EXP_BITS-1:0]              exp_store;
    logic [EXP_BITS-1:0]              exp_work;
    logic [$clog2(EXP_BITS+1)-1:0]    bit_cnt;
    idx_t                             x_cnt;
    logic                             last_bit;

    // --------------------
    // exponent storage
    // --------------------

    // newest word lands on top, so the last one given is the msw
    always_ff @(posedge clk) begin
        if (y_valid) begin
            exp_store <= {y_word, exp_store[EXP_BITS-1:WORD_W]};
        end
    end

    // working copy, shifted left once per square
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            exp_work <= exp_store;
        end else if (state == S_SQUARE && mul_done) begin
            exp_work <= exp_work << 1;
        end
    end

    assign last_bit = (bit_cnt == EXP_BITS - 1);

    // --------------------
    // control FSM
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            mul_start <= 1'b0;
            bit_cnt   <= '0;
            x_cnt     <= '0;
        end else begin
            mul_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_LOAD_X;
                        x_cnt   <= '0;
                        bit_cnt <= '0;
                    end
                end
                S_LOAD_X: begin
                    if (x_valid) begin
                        x_cnt <= x_cnt + 1'b1;
                        if (x_cnt == idx_t'(N_WORDS - 1)) begin
                            state     <= S_CONV_IN;
                            mul_start <= 1'b1;
                        end
                    end
                end
                S_CONV_IN: begin
                    if (mul_done) begin
                        state     <= S_SQUARE;
                        mul_start <= 1'b1;
                    end
                end
                S_SQUARE: begin
                    // decide on the bit that is shifted out now
                    if (mul_done) begin
                        bit_cnt   <= bit_cnt + 1'b1;
                        mul_start <= 1'b1;
                        if (exp_work[EXP_BITS-1]) begin
                            state <= S_MULT;
                        end else if (last_bit) begin
                            state <= S_CONV_OUT;
                        end
                    end
                end
                S_MULT: begin
                    // bit_cnt already counts this bit
                    if (mul_done) begin
                        mul_start <= 1'b1;
                        if (bit_cnt == EXP_BITS) begin
                            state <= S_CONV_OUT;
                        end else begin
                            state <= S_SQUARE;
                        end
                    end
                end
                S_CONV_OUT: begin
                    if (mul_done) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // bank controls
    // --------------------

    assign busy     = (state != S_IDLE);
    assign acc_init = (state == S_IDLE) && start;
    assign x_we     = (state == S_LOAD_X) && x_valid;
    assign x_idx    = x_cnt;

    // held for the whole job, write-back included
    always_comb begin
        src_a = SRC_A_ACC;
        src_b = SRC_B_ACC;
        dst   = DST_ACC;
        case (state)
            S_CONV_IN: begin
                src_a = SRC_A_X;
                src_b = SRC_B_R2;
                dst   = DST_XM;
            end
            S_MULT: begin
                src_b = SRC_B_XM;
            end
            S_CONV_OUT: begin
                src_b = SRC_B_ONE;
                dst   = DST_OUT;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/operand_bank.sv
`timescale 1ns/1ns

module operand_bank (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    x_we,
    input  mont_arith_pkg::idx_t    x_idx,
    input  mont_arith_pkg::word_t   x_word,
    input  logic                    acc_init,
    input  mont_const_pkg::src_a_t  src_a,
    input  mont_const_pkg::src_b_t  src_b,
    input  mont_const_pkg::dst_t    dst,
    input  mont_arith_pkg::idx_t    a_idx,
    input  mont_arith_pkg::idx_t    b_idx,
    output mont_arith_pkg::word_t   a_word,
    output mont_arith_pkg::word_t   b_word,
    input  logic                    res_we,
    input  mont_arith_pkg::idx_t    res_idx,
    input  mont_arith_pkg::word_t   res_word,
    output logic                    result_valid,
    output mont_arith_pkg::word_t   result_word
);

    import mont_arith_pkg::*;
    import mont_const_pkg::*;

    // raw base, montgomery base, accumulator
    word_t x_raw  [N_WORDS];
    word_t x_mont [N_WORDS];
    word_t acc    [N_WORDS];

    // --------------------
    // storage
    // --------------------

    always_ff @(posedge clk) begin
        if (x_we) begin
            x_raw[x_idx] <= x_word;
        end
        // acc starts each run as montgomery one
        if (acc_init) begin
            for (int k = 0; k < N_WORDS; k++) begin
                acc[k] <= R_MOD_M[k*WORD_W +: WORD_W];
            end
        end else if (res_we && dst == DST_ACC) begin
            acc[res_idx] <= res_word;
        end
        if (res_we && dst == DST_XM) begin
            x_mont[res_idx] <= res_word;
        end
    end

    // --------------------
    // operand muxing
    // --------------------

    assign a_word = (src_a == SRC_A_X) ? x_raw[a_idx] : acc[a_idx];

    always_comb begin
        case (src_b)
            SRC_B_R2:  b_word = R2_MOD_M[b_idx*WORD_W +: WORD_W];
            SRC_B_XM:  b_word = x_mont[b_idx];
            SRC_B_ACC: b_word = acc[b_idx];
            default:   b_word = (b_idx == '0) ? word_t'(1) : '0;
        endcase
    end

    // final conversion goes out one word per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= res_we && (dst == DST_OUT);
        end
    end

    always_ff @(posedge clk) begin
        if (res_we && dst == DST_OUT) begin
            result_word <= res_word;
        end
    end

endmodule

// File: verilog/mont_multiplier.sv
`timescale 1ns/1ns

module mont_multiplier (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mul_start,
    input  mont_arith_pkg::word_t  a_word,
    input  mont_arith_pkg::word_t  b_word,
    output mont_arith_pkg::idx_t   a_idx,
    output mont_arith_pkg::idx_t   b_idx,
    output logic                   res_we,
    output mont_arith_pkg::idx_t   res_idx,
    output mont_arith_pkg::word_t  res_word,
    output logic                   mul_done
);

    import mont_arith_pkg::*;
    import mont_const_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_LOOP, M_SUB, M_WB} mstate_t;

    mstate_t                           state;
    logic [$clog2(2*N_WORDS+2)-1:0]    step;
    idx_t                              b_sel;
    idx_t                              wb_idx;
    word_t                             t [N_WORDS+2];
    word_t                             carry;
    word_t                             q;
    operand_t                          res_reg;
    logic                              mac_phase;
    logic                              red_phase;
    logic                              last_step;
    idx_t                              red_idx;
    word_t                             op_x;
    word_t                             op_y;
    word_t                             addend;
    logic [2*WORD_W-1:0]               mac;
    logic [WORD_W:0]                   top_sum;
    operand_t                          t_low;
    logic [OP_W:0]                     diff;

    // --------------------
    // step decode
    // --------------------

    // per B word: N mac steps, one carry step, N reduce steps, one shift step
    assign mac_phase = (step < N_WORDS);
    assign red_phase = (step > N_WORDS) && (step <= 2 * N_WORDS);
    assign last_step = (step == 2 * N_WORDS + 1);
    assign red_idx   = idx_t'(step - (N_WORDS + 1));

    assign a_idx = idx_t'(step);
    assign b_idx = b_sel;

    // single word multiplier shared by both phases
    always_comb begin
        if (red_phase) begin
            op_x   = q;
            op_y   = MODULUS[red_idx*WORD_W +: WORD_W];
            addend = t[red_idx];
        end else begin
            op_x   = a_word;
            op_y   = b_word;
            addend = t[a_idx];
        end
        mac = op_x * op_y + addend + carry;
    end

    assign top_sum = t[N_WORDS] + carry;

    always_comb begin
        for (int k = 0; k < N_WORDS; k++) begin
            t_low[k*WORD_W +: WORD_W] = t[k];
        end
    end

    // sum is below 2m, one conditional subtract is enough
    assign diff = {t[N_WORDS][0], t_low} - {1'b0, MODULUS};

    // --------------------
    // control
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= M_IDLE;
            step     <= '0;
            b_sel    <= '0;
            wb_idx   <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (mul_start) begin
                        state <= M_LOOP;
                        step  <= '0;
                        b_sel <= '0;
                    end
                end
                M_LOOP: begin
                    if (last_step) begin
                        step <= '0;
                        if (b_sel == idx_t'(N_WORDS - 1)) begin
                            state <= M_SUB;
                        end else begin
                            b_sel <= b_sel + 1'b1;
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                M_SUB: begin
                    state  <= M_WB;
                    wb_idx <= '0;
                end
                default: begin
                    if (wb_idx == idx_t'(N_WORDS - 1)) begin
                        state    <= M_IDLE;
                        mul_done <= 1'b1;
                    end else begin
                        wb_idx <= wb_idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // --------------------
    // datapath
    // --------------------

    always_ff @(posedge clk) begin
        if (state == M_IDLE && mul_start) begin
            for (int k = 0; k < N_WORDS + 2; k++) begin
                t[k] <= '0;
            end
            carry <= '0;
        end else if (state == M_LOOP) begin
            if (mac_phase) begin
                t[a_idx] <= mac[WORD_W-1:0];
                carry    <= mac[2*WORD_W-1:WORD_W];
            end else if (step == N_WORDS) begin
                // t[0] is final here, so q can be formed alongside the carry
                t[N_WORDS]   <= top_sum[WORD_W-1:0];
                t[N_WORDS+1] <= word_t'(top_sum[WORD_W]);
                q            <= t[0] * M_PRIME;
                carry        <= '0;
            end else if (red_phase) begin
                // low word of step 0 is zero by choice of q
                if (red_idx != '0) begin
                    t[red_idx - 1'b1] <= mac[WORD_W-1:0];
                end
                carry <= mac[2*WORD_W-1:WORD_W];
            end else begin
                t[N_WORDS-1] <= top_sum[WORD_W-1:0];
                t[N_WORDS]   <= t[N_WORDS+1] + word_t'(top_sum[WORD_W]);
                carry        <= '0;
            end
        end else if (state == M_SUB) begin
            res_reg <= diff[OP_W] ? t_low : diff[OP_W-1:0];
        end
    end

    assign res_we   = (state == M_WB);
    assign res_idx  = wb_idx;
    assign res_word = res_reg[wb_idx*WORD_W +: WORD_W];

endmodule

// File: verilog/modexp_top.sv
`timescale 1ns/1ns

module modexp_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   x_valid,
    input  logic                   y_valid,
    input  mont_arith_pkg::word_t  x_word,
    input  mont_arith_pkg::word_t  y_word,
    output logic                   busy,
    output logic                   result_valid,
    output mont_arith_pkg::word_t  result_word
);

    import mont_arith_pkg::*;
    import mont_const_pkg::*;

    // sequencer to bank
    logic    x_we;
    logic    acc_init;
    idx_t    x_idx;
    src_a_t  src_a;
    src_b_t  src_b;
    dst_t    dst;

    // multiplier handshake and operand traffic
    logic    mul_start;
    logic    mul_done;
    idx_t    a_idx;
    idx_t    b_idx;
    word_t   a_word;
    word_t   b_word;
    logic    res_we;
    idx_t    res_idx;
    word_t   res_word;

    exp_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .x_valid   (x_valid),
        .y_valid   (y_valid),
        .y_word    (y_word),
        .mul_done  (mul_done),
        .busy      (busy),
        .mul_start (mul_start),
        .x_we      (x_we),
        .acc_init  (acc_init),
        .x_idx     (x_idx),
        .src_a     (src_a),
        .src_b     (src_b),
        .dst       (dst)
    );

    operand_bank u_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .x_we         (x_we),
        .x_idx        (x_idx),
        .x_word       (x_word),
        .acc_init     (acc_init),
        .src_a        (src_a),
        .src_b        (src_b),
        .dst          (dst),
        .a_idx        (a_idx),
        .b_idx        (b_idx),
        .a_word       (a_word),
        .b_word       (b_word),
        .res_we       (res_we),
        .res_idx      (res_idx),
        .res_word     (res_word),
        .result_valid (result_valid),
        .result_word  (result_word)
    );

    mont_multiplier u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .a_word    (a_word),
        .b_word    (b_word),
        .a_idx     (a_idx),
        .b_idx     (b_idx),
        .res_we    (res_we),
        .res_idx   (res_idx),
        .res_word  (res_word),
        .mul_done  (mul_done)
    );

endmodule

// File: test/modexp_assert.sv
`timescale 1ns/1ns

module modexp_assert (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic result_valid,
    input logic mul_start,
    input logic mul_done
);

    logic mul_pending;

    // high from a multiply request until its done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_pending <= 1'b0;
        end else if (mul_start) begin
            mul_pending <= 1'b1;
        end else if (mul_done) begin
            mul_pending <= 1'b0;
        end
    end

    // --------------------
    // protocol rules
    // --------------------

    no_result_on_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |-> !result_valid)
        else $error("result_valid high while a start is accepted");

    one_mul_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> !mul_pending)
        else $error("mul_start issued before the previous mul_done");

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy)
        else $error("busy did not rise after an accepted start");

    result_inside_busy: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> busy)
        else $error("result_valid high while not busy");

    // busy only drops right after the last result word
    busy_ends_after_result: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(result_valid))
        else $error("busy fell without a preceding result word");

endmodule

bind modexp_top modexp_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .result_valid (result_valid),
    .mul_start    (mul_start),
    .mul_done     (mul_done)
);

// File: test/modexp_tb.sv
`timescale 1ns/1ns

module modexp_tb;

    import mont_arith_pkg::*;
    import mont_const_pkg::*;

    // one multiply is 46 cycles and the sequencer needs one more to restart it
    localparam int MUL_CYCLES  = 47;
    localparam int MAX_MULS    = 2 * EXP_BITS + 2;
    localparam int RUN_LIMIT   = MAX_MULS * MUL_CYCLES + 100;
    localparam int N_RUNS      = 12;
    localparam int CYCLE_LIMIT = N_RUNS * (RUN_LIMIT + 100) + 1000;

    localparam logic [2*OP_W-1:0] MOD_WIDE = {{OP_W{1'b0}}, MODULUS};

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        x_valid;
    logic        y_valid;
    word_t       x_word;
    word_t       y_word;
    logic        busy;
    logic        result_valid;
    word_t       result_word;

    logic [31:0] rng_state;
    int          errors;
    int          timeouts;
    int          cycles;

    modexp_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .x_valid      (x_valid),
        .y_valid      (y_valid),
        .x_word       (x_word),
        .y_word       (y_word),
        .busy         (busy),
        .result_valid (result_valid),
        .result_word  (result_word)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // hard stop in case the DUT never finishes
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // helpers
    // --------------------

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic operand_t rand_operand();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    // plain square and multiply from the msb with full width products
    function automatic operand_t ref_modexp(operand_t base, operand_t e);
        logic [2*OP_W-1:0] prod;
        operand_t          acc;
        acc = operand_t'(1);
        for (int i = EXP_BITS - 1; i >= 0; i--) begin
            prod = {{OP_W{1'b0}}, acc} * {{OP_W{1'b0}}, acc};
            acc  = operand_t'(prod % MOD_WIDE);
            if (e[i]) begin
                prod = {{OP_W{1'b0}}, acc} * {{OP_W{1'b0}}, base};
                acc  = operand_t'(prod % MOD_WIDE);
            end
        end
        return acc;
    endfunction

    task automatic check_word(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        if (got !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // --------------------
    // stimulus
    // --------------------

    // all tasks start and end on a falling edge

    task automatic load_exponent(operand_t e);
        for (int i = 0; i < N_WORDS; i++) begin
            y_valid = 1'b1;
            y_word  = e[i*WORD_W +: WORD_W];
            @(negedge clk);
        end
        y_valid = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic send_base(operand_t x, int max_gap);
        int gap;
        for (int i = 0; i < N_WORDS; i++) begin
            gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
            if (gap > 0) begin
                x_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            x_valid = 1'b1;
            x_word  = x[i*WORD_W +: WORD_W];
            @(negedge clk);
        end
        x_valid = 1'b0;
    endtask

    // a second start while busy must not disturb the job
    task automatic start_while_busy();
        repeat (20) @(negedge clk);
        check_bit("busy", busy, 1'b1);
        pulse_start();
    endtask

    task automatic collect_result(operand_t expected);
        int waited;
        waited = 0;
        while (!result_valid && waited < RUN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!result_valid) begin
            $display("no result word appeared within %0d cycles", RUN_LIMIT);
            timeouts++;
        end else begin
            // four words back to back with the lsw first
            for (int i = 0; i < N_WORDS; i++) begin
                if (i > 0) begin
                    check_bit("result_valid", result_valid, 1'b1);
                end
                check_bit("busy", busy, 1'b1);
                check_word($sformatf("result_word[%0d]", i), result_word,
                           expected[i*WORD_W +: WORD_W]);
                @(negedge clk);
            end
            check_bit("result_valid", result_valid, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
    endtask

    task automatic run_case(operand_t x, operand_t e, int max_gap, bit poke);
        operand_t expected;
        expected = ref_modexp(x, e);
        load_exponent(e);
        pulse_start();
        send_base(x, max_gap);
        if (poke) begin
            start_while_busy();
        end
        collect_result(expected);
    endtask

    // --------------------
    // tests
    // --------------------

    task automatic test_reset_idle();
        for (int i = 0; i < 20; i++) begin
            check_bit("busy", busy, 1'b0);
            check_bit("result_valid", result_valid, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic test_directed();
        run_case(operand_t'(2), operand_t'(10), 0, 1'b0);
        run_case(64'h0123_4567_89ab_cdef, operand_t'(0), 0, 1'b0);
        run_case(operand_t'(0), operand_t'(7), 0, 1'b0);
    endtask

    task automatic test_random();
        for (int i = 0; i < 5; i++) begin
            run_case(rand_operand() % MODULUS, rand_operand(), 0, 1'b0);
        end
    endtask

    task automatic test_base_gaps();
        for (int i = 0; i < 2; i++) begin
            run_case(rand_operand() % MODULUS, rand_operand(), 3, 1'b0);
        end
    endtask

    task automatic test_back_to_back();
        run_case(rand_operand() % MODULUS, rand_operand(), 0, 1'b1);
        run_case(rand_operand() % MODULUS, rand_operand(), 1, 1'b0);
    endtask

    initial begin
        rng_state = 32'h8bbccc1c;
        errors    = 0;
        timeouts  = 0;
        cycles    = 0;
        rst_n     = 1'b0;
        start     = 1'b0;
        x_valid   = 1'b0;
        y_valid   = 1'b0;
        x_word    = '0;
        y_word    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_idle();
        test_directed();
        test_random();
        test_base_gaps();
        test_back_to_back();

        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/mont_arith_pkg.sv
verilog/mont_const_pkg.sv
verilog/exp_sequencer.sv
verilog/operand_bank.sv
verilog/mont_multiplier.sv
verilog/modexp_top.sv
test/modexp_assert.sv
test/modexp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module modexp_tb \
    -f filelist.f \
    -o modexp_sim

./obj_dir/modexp_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
